// File: src/lpif_link_pkg.sv
`default_nettype none

package lpif_link_pkg;

  //////////////////////////////////////////////////////////////////////
  // User bus field widths

  localparam int LPIF_STATE_W  = 4;
  localparam int LPIF_PROTID_W = 2;
  localparam int LPIF_DATA_W   = 256;
  localparam int LPIF_BSTART_W = 5;
  localparam int LPIF_BVALID_W = 32;
  localparam int LPIF_BYTE_W   = 8;

  // Full flat link word, valid bit included
  localparam int LPIF_WORD_W = LPIF_STATE_W + LPIF_PROTID_W + LPIF_DATA_W +
                               LPIF_BSTART_W + LPIF_BVALID_W + 1;

  //////////////////////////////////////////////////////////////////////
  // PHY channel layout

  localparam int PHY_CH_N      = 4;
  localparam int PHY_W         = 80;
  localparam int PHY_PAYLOAD_W = PHY_W - 2;

  // Payload bits over all channels, top of last channel is padding
  localparam int PHY_FLAT_W = PHY_CH_N * PHY_PAYLOAD_W;
  localparam int PHY_PAD_W  = PHY_FLAT_W - LPIF_WORD_W;

  // Strobe spacing in online words
  localparam int STROBE_PERIOD = 16;
  localparam int STB_CNT_W     = $clog2(STROBE_PERIOD);

  //////////////////////////////////////////////////////////////////////
  // Types

  typedef enum logic [LPIF_PROTID_W-1:0] {
    PROT_MEM    = 2'd0,
    PROT_IO     = 2'd1,
    PROT_CACHE  = 2'd2,
    PROT_STREAM = 2'd3
  } lpif_protid_t;

  // Same layout for downstream and upstream
  typedef struct packed {
    logic [LPIF_STATE_W-1:0]  state;
    lpif_protid_t             protid;
    logic [LPIF_DATA_W-1:0]   data;
    logic [LPIF_BSTART_W-1:0] bstart;
    logic [LPIF_BVALID_W-1:0] bvalid;
    logic                     valid;
  } lpif_word_t;

  // One channel word, strobe at bit 79 and marker at bit 78
  typedef struct packed {
    logic                     stb;
    logic                     mrk;
    logic [PHY_PAYLOAD_W-1:0] payload;
  } phy_word_t;

  typedef enum logic [1:0] {
    SYNC_OFFLINE = 2'd0,
    SYNC_WAIT_RX = 2'd1,
    SYNC_WAIT_TX = 2'd2,
    SYNC_ONLINE  = 2'd3
  } sync_state_t;

endpackage

`default_nettype wire

// File: src/lpif_auto_sync.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_auto_sync
  import lpif_link_pkg::*;
(
  input  logic       clk_wr,
  input  logic       arst_n,
  input  logic       tx_online,
  input  logic       rx_online,
  input  logic [7:0] delay_x_value,
  input  logic [7:0] delay_xz_value,
  input  logic [7:0] delay_yz_value,
  output logic       tx_online_dly,
  output logic       rx_online_dly,
  output logic       auto_stb,
  output logic       auto_mrk
);

  sync_state_t          state;
  sync_state_t          state_nxt;
  logic [7:0]           dly_cnt;
  logic [7:0]           xz_cnt;
  logic [STB_CNT_W-1:0] stb_cnt;
  logic                 rx_done;
  logic                 xz_done;
  logic                 yz_done;

  //////////////////////////////////////////////////////////////////////
  // Alignment wait

  // Counts include the current cycle
  assign rx_done = ({1'b0, dly_cnt} + 9'd1) >= {1'b0, delay_x_value};
  assign yz_done = ({1'b0, dly_cnt} + 9'd1) >= {1'b0, delay_yz_value};
  assign xz_done = tx_online && (({1'b0, xz_cnt} + 9'd1) >= {1'b0, delay_xz_value});

  always_comb begin
    state_nxt = state;
    case (state)
      SYNC_OFFLINE: if (rx_online) state_nxt = rx_done ? SYNC_WAIT_TX : SYNC_WAIT_RX;
      SYNC_WAIT_RX: if (rx_done) state_nxt = SYNC_WAIT_TX;
      SYNC_WAIT_TX: if (xz_done && yz_done) state_nxt = SYNC_ONLINE;
      SYNC_ONLINE:  if (!tx_online) state_nxt = SYNC_WAIT_TX;
      default:      state_nxt = SYNC_OFFLINE;
    endcase
    // Losing rx drops the whole link
    if (!rx_online) begin
      state_nxt = SYNC_OFFLINE;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      state <= SYNC_OFFLINE;
    end else begin
      state <= state_nxt;
    end
  end

  // Shared counter, delay_x first, then time since rx_online_dly rose
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      dly_cnt <= '0;
    end else if (state_nxt == SYNC_OFFLINE) begin
      dly_cnt <= '0;
    end else if (state_nxt == SYNC_WAIT_TX &&
                 (state == SYNC_OFFLINE || state == SYNC_WAIT_RX)) begin
      dly_cnt <= '0;
    end else if (dly_cnt != 8'hff) begin
      dly_cnt <= dly_cnt + 8'd1;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      xz_cnt <= '0;
    end else if (!tx_online) begin
      xz_cnt <= '0;
    end else if (xz_cnt != 8'hff) begin
      xz_cnt <= xz_cnt + 8'd1;
    end
  end

  assign rx_online_dly = (state == SYNC_WAIT_TX) || (state == SYNC_ONLINE);
  assign tx_online_dly = (state == SYNC_ONLINE);

  //////////////////////////////////////////////////////////////////////
  // Strobe and marker generation

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stb_cnt <= '0;
    end else if (!tx_online_dly || stb_cnt == STB_CNT_W'(STROBE_PERIOD - 1)) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 1'b1;
    end
  end

  assign auto_stb = tx_online_dly && (stb_cnt == '0);
  assign auto_mrk = tx_online_dly;

  a_tx_after_rx: assert property (@(posedge clk_wr) disable iff (!arst_n)
    tx_online_dly |-> $past(rx_online_dly));

  // Both delayed indications drop one clock after rx_online
  a_rx_drop: assert property (@(posedge clk_wr) disable iff (!arst_n)
    !rx_online |=> (!rx_online_dly && !tx_online_dly));

endmodule

`default_nettype wire

// File: src/lpif_user_pack.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_user_pack
  import lpif_link_pkg::*;
(
  input  logic       clk_wr,
  input  logic       arst_n,
  input  lpif_word_t dstrm,
  input  lpif_word_t rx_word,
  input  logic       rx_word_ok,
  output lpif_word_t tx_word,
  output lpif_word_t ustrm
);

  lpif_word_t ustrm_pl;
  logic       ustrm_vld;

  //////////////////////////////////////////////////////////////////////
  // Downstream

  // Zero bytes without a bvalid bit before they cross the link
  always_comb begin
    tx_word = dstrm;
    for (int b = 0; b < LPIF_BVALID_W; b++) begin
      if (!dstrm.bvalid[b]) begin
        tx_word.data[b*LPIF_BYTE_W +: LPIF_BYTE_W] = '0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Upstream

  always_ff @(posedge clk_wr) begin
    ustrm_pl <= rx_word;
  end

  // Valid only for words that passed the marker check
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      ustrm_vld <= 1'b0;
    end else begin
      ustrm_vld <= rx_word.valid && rx_word_ok;
    end
  end

  always_comb begin
    ustrm       = ustrm_pl;
    ustrm.valid = ustrm_vld;
  end

endmodule

`default_nettype wire

// File: src/lpif_phy_stripe.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_phy_stripe
  import lpif_link_pkg::*;
(
  input  logic                     clk_wr,
  input  logic                     arst_n,
  input  lpif_word_t               tx_word,
  input  logic                     tx_online_dly,
  input  logic                     auto_stb,
  input  logic                     auto_mrk,
  input  logic                     rx_online_dly,
  output phy_word_t [PHY_CH_N-1:0] tx_phy,
  input  phy_word_t [PHY_CH_N-1:0] rx_phy,
  output lpif_word_t               rx_word,
  output logic                     rx_word_ok,
  output logic [31:0]              tx_debug_status,
  output logic [31:0]              rx_debug_status
);

  logic [PHY_FLAT_W-1:0]    tx_flat;
  logic [PHY_FLAT_W-1:0]    rx_flat;
  phy_word_t [PHY_CH_N-1:0] tx_phy_nxt;
  logic [PHY_CH_N-1:0]      tx_stb_vec;
  logic [PHY_CH_N-1:0]      tx_mrk_vec;
  logic [PHY_CH_N-1:0]      rx_mrk_vec;
  logic                     rx_mrk_all;
  logic                     rx_mrk_some;

  //////////////////////////////////////////////////////////////////////
  // TX striping

  // Padding lands at the top of the last channel
  assign tx_flat = {{PHY_PAD_W{1'b0}}, tx_word};

  always_comb begin
    for (int i = 0; i < PHY_CH_N; i++) begin
      tx_phy_nxt[i].stb     = auto_stb;
      tx_phy_nxt[i].mrk     = auto_mrk;
      tx_phy_nxt[i].payload = tx_flat[i*PHY_PAYLOAD_W +: PHY_PAYLOAD_W];
    end
  end

  // Channels idle at zero until the link is up
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy <= '0;
    end else if (tx_online_dly) begin
      tx_phy <= tx_phy_nxt;
    end else begin
      tx_phy <= '0;
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_debug_status <= '0;
    end else if (tx_online_dly && tx_word.valid) begin
      tx_debug_status <= tx_debug_status + 32'd1;
    end
  end

  always_comb begin
    for (int i = 0; i < PHY_CH_N; i++) begin
      tx_stb_vec[i] = tx_phy[i].stb;
      tx_mrk_vec[i] = tx_phy[i].mrk;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // RX de-striping and marker check

  always_comb begin
    for (int i = 0; i < PHY_CH_N; i++) begin
      rx_flat[i*PHY_PAYLOAD_W +: PHY_PAYLOAD_W] = rx_phy[i].payload;
      rx_mrk_vec[i] = rx_phy[i].mrk;
    end
  end

  assign rx_word     = lpif_word_t'(rx_flat[LPIF_WORD_W-1:0]);
  assign rx_mrk_all  = &rx_mrk_vec;
  assign rx_mrk_some = |rx_mrk_vec;
  assign rx_word_ok  = rx_online_dly && rx_mrk_all;

  // Misaligned word: some channels carry a marker and some do not.
  // An all-zero idle word is not a misalignment.
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_debug_status <= '0;
    end else if (rx_online_dly && rx_mrk_some && !rx_mrk_all) begin
      rx_debug_status <= rx_debug_status + 32'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Channel word format

  a_stb_aligned: assert property (@(posedge clk_wr) disable iff (!arst_n)
    (|tx_stb_vec) |-> ((&tx_stb_vec) && (&tx_mrk_vec)));

endmodule

`default_nettype wire

// File: src/lpif_link_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_link_master_top
  import lpif_link_pkg::*;
(
  input  logic                     clk_wr,
  input  logic                     arst_n,

  // Link control
  input  logic                     tx_online,
  input  logic                     rx_online,
  input  logic [7:0]               delay_x_value,
  input  logic [7:0]               delay_xz_value,
  input  logic [7:0]               delay_yz_value,

  // User bus
  input  lpif_word_t               dstrm,
  output lpif_word_t               ustrm,

  // PHY channels
  output phy_word_t [PHY_CH_N-1:0] tx_phy,
  input  phy_word_t [PHY_CH_N-1:0] rx_phy,

  // Debug status
  output logic [31:0]              tx_downstream_debug_status,
  output logic [31:0]              rx_upstream_debug_status
);

  lpif_word_t tx_word;
  lpif_word_t rx_word;
  logic       rx_word_ok;
  logic       tx_online_dly;
  logic       rx_online_dly;
  logic       auto_stb;
  logic       auto_mrk;

  //////////////////////////////////////////////////////////////////////
  // Online delay and automatic sync bits

  lpif_auto_sync u_auto_sync (
    .clk_wr         (clk_wr),
    .arst_n         (arst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_xz_value (delay_xz_value),
    .delay_yz_value (delay_yz_value),
    .tx_online_dly  (tx_online_dly),
    .rx_online_dly  (rx_online_dly),
    .auto_stb       (auto_stb),
    .auto_mrk       (auto_mrk)
  );

  //////////////////////////////////////////////////////////////////////
  // User side

  lpif_user_pack u_user_pack (
    .clk_wr     (clk_wr),
    .arst_n     (arst_n),
    .dstrm      (dstrm),
    .rx_word    (rx_word),
    .rx_word_ok (rx_word_ok),
    .tx_word    (tx_word),
    .ustrm      (ustrm)
  );

  //////////////////////////////////////////////////////////////////////
  // PHY side

  lpif_phy_stripe u_phy_stripe (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_word         (tx_word),
    .tx_online_dly   (tx_online_dly),
    .auto_stb        (auto_stb),
    .auto_mrk        (auto_mrk),
    .rx_online_dly   (rx_online_dly),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .rx_word         (rx_word),
    .rx_word_ok      (rx_word_ok),
    .tx_debug_status (tx_downstream_debug_status),
    .rx_debug_status (rx_upstream_debug_status)
  );

endmodule

`default_nettype wire

// File: tb/tb_lpif_ref.svh
`ifndef TB_LPIF_REF_SVH
`define TB_LPIF_REF_SVH

typedef phy_word_t [PHY_CH_N-1:0] phy_bus_t;

//////////////////////////////////////////////////////////////////////
// Expected values

// Bytes without a bvalid bit read back as zero
function automatic lpif_word_t ref_mask(input lpif_word_t w);
  lpif_word_t             m;
  logic [LPIF_DATA_W-1:0] keep;
  for (int b = 0; b < LPIF_BVALID_W; b++) begin
    keep[b*8 +: 8] = {8{w.bvalid[b]}};
  end
  m      = w;
  m.data = w.data & keep;
  return m;
endfunction

// Channel 0 takes the lowest payload bits, top of channel 3 is zero
function automatic phy_bus_t ref_stripe(input lpif_word_t w, input logic stb, input logic mrk);
  phy_bus_t              bus;
  logic [PHY_FLAT_W-1:0] flat;
  flat                    = '0;
  flat[LPIF_WORD_W-1:0]   = w;
  for (int i = 0; i < PHY_CH_N; i++) begin
    bus[i].stb     = stb;
    bus[i].mrk     = mrk;
    bus[i].payload = flat[i*PHY_PAYLOAD_W +: PHY_PAYLOAD_W];
  end
  return bus;
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks

task automatic check_word(input string what, input lpif_word_t exp, input lpif_word_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_phy(input string what, input phy_word_t exp, input phy_word_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_count(input string what, input logic [31:0] exp, input logic [31:0] act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("Fail %s %s: expected %0d actual %0d", test_name, what, exp, act);
  end
endtask

`endif

// File: tb/tb_lpif_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lpif_link
  import lpif_link_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int DLY_X      = 3;
  localparam int DLY_XZ     = 2;
  localparam int DLY_YZ     = 4;
  localparam int UP_CYCLES  = DLY_X + DLY_YZ + 1;
  localparam int FAULT_CH   = 2;
  localparam int WAIT_LIMIT = 40;

  typedef struct packed {
    logic [31:0] cyc;
    logic        on;
    logic        fault;
    lpif_word_t  word;
  } sent_t;

  string test_name;
  int    err_cnt;
  int    chk_cnt;

  `include "tb_lpif_ref.svh"

  logic        clk_wr;
  logic        arst_n;
  logic        tx_online;
  logic        rx_online;
  logic [7:0]  delay_x_value;
  logic [7:0]  delay_xz_value;
  logic [7:0]  delay_yz_value;
  lpif_word_t  dstrm;
  lpif_word_t  ustrm;
  phy_bus_t    tx_phy;
  phy_bus_t    rx_phy;
  logic [31:0] tx_downstream_debug_status;
  logic [31:0] rx_upstream_debug_status;

  logic [31:0] cyc = '0;
  logic        fault_in;
  logic        fault_dly = 1'b0;
  logic [31:0] rng_state;
  logic [31:0] link_up_cyc;
  sent_t       phy_q[$];
  sent_t       ust_q[$];
  int          stb_seen;
  int          n_valid_sent;
  int          n_tests;
  int          n_failed;
  int          test_err0;

  lpif_link_master_top DUT (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_xz_value             (delay_xz_value),
    .delay_yz_value             (delay_yz_value),
    .dstrm                      (dstrm),
    .ustrm                      (ustrm),
    .tx_phy                     (tx_phy),
    .rx_phy                     (rx_phy),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD/2) clk_wr = ~clk_wr;
  end

  always @(posedge clk_wr) begin
    cyc       <= cyc + 32'd1;
    fault_dly <= fault_in;
  end

  // Loopback, one marker pulled low while a fault word is on the wire
  always_comb begin
    rx_phy = tx_phy;
    if (fault_dly) begin
      rx_phy[FAULT_CH].mrk = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic lpif_word_t rand_word(input logic valid);
    lpif_word_t  w;
    logic [31:0] r;
    for (int i = 0; i < LPIF_DATA_W / 32; i++) begin
      w.data[i*32 +: 32] = lcg_next();
    end
    w.bvalid = lcg_next();
    r        = lcg_next();
    w.state  = r[3:0];
    w.protid = lpif_protid_t'(r[5:4]);
    w.bstart = r[10:6];
    w.valid  = valid;
    return w;
  endfunction

  task automatic send_word(input lpif_word_t w, input logic on, input logic fault);
    sent_t e;
    @(posedge clk_wr);
    #2;
    dstrm    = w;
    fault_in = fault;
    e.cyc    = cyc;
    e.on     = on;
    e.fault  = fault;
    e.word   = w;
    phy_q.push_back(e);
    ust_q.push_back(e);
    if (on && w.valid) begin
      n_valid_sent++;
    end
  endtask

  task automatic wait_drain();
    int n;
    // Idle the bus once the last word is taken, so it is not sent again
    @(posedge clk_wr);
    #2;
    dstrm = '0;
    n     = 0;
    while ((phy_q.size() != 0 || ust_q.size() != 0) && n < WAIT_LIMIT) begin
      @(negedge clk_wr);
      #1;
      n++;
    end
    if (phy_q.size() != 0 || ust_q.size() != 0) begin
      err_cnt++;
      $display("Error in %s: sent words never came back within %0d cycles", test_name, n);
      phy_q.delete();
      ust_q.delete();
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    n_tests++;
    if (err_cnt == test_err0) begin
      $display("Test %-12s ok", test_name);
    end else begin
      n_failed++;
      $display("Test %-12s failed with %0d errors", test_name, err_cnt - test_err0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare process, tx_phy one cycle and ustrm two cycles after send

  initial begin : compare_proc
    sent_t      e;
    phy_bus_t   exp_bus;
    lpif_word_t exp_w;
    logic       stb_exp;
    forever begin
      @(negedge clk_wr);
      if (phy_q.size() > 0 && phy_q[0].cyc + 32'd1 == cyc) begin
        e       = phy_q.pop_front();
        stb_exp = ((cyc - link_up_cyc) % STROBE_PERIOD) == 0;
        exp_bus = e.on ? ref_stripe(ref_mask(e.word), stb_exp, 1'b1) : '0;
        for (int i = 0; i < PHY_CH_N; i++) begin
          check_phy($sformatf("tx_phy[%0d]", i), exp_bus[i], tx_phy[i]);
        end
        if (tx_phy[0].stb) begin
          stb_seen++;
        end
      end
      if (ust_q.size() > 0 && ust_q[0].cyc + 32'd2 == cyc) begin
        e = ust_q.pop_front();
        if (e.on) begin
          exp_w       = ref_mask(e.word);
          exp_w.valid = e.word.valid && !e.fault;
        end else begin
          exp_w = '0;
        end
        check_word("ustrm", exp_w, ustrm);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin : main_proc
    logic [31:0] r;
    logic [31:0] c0;
    logic [31:0] rx_base;
    phy_bus_t    first_bus;
    int          n;
    logic        found;
    rng_state      = 32'd83;
    link_up_cyc    = '0;
    arst_n         = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_x_value  = 8'(DLY_X);
    delay_xz_value = 8'(DLY_XZ);
    delay_yz_value = 8'(DLY_YZ);
    dstrm          = '0;
    fault_in       = 1'b0;
    repeat (2) @(posedge clk_wr);
    #2;
    arst_n = 1'b1;

    start_test("reset_state");
    for (n = 0; n < 12; n++) begin
      send_word(rand_word(1'b1), 1'b0, 1'b0);
      @(negedge clk_wr);
      check_count("tx_dbg", 32'd0, tx_downstream_debug_status);
      check_count("rx_dbg", 32'd0, rx_upstream_debug_status);
      check_count("ustrm_valid", 32'd0, {31'b0, ustrm.valid});
    end
    wait_drain();
    end_test();

    start_test("online_seq");
    @(posedge clk_wr);
    #2;
    dstrm       = '0;
    tx_online   = 1'b1;
    rx_online   = 1'b1;
    c0          = cyc;
    link_up_cyc = c0 + UP_CYCLES;
    found       = 1'b0;
    n           = 0;
    while (!found && n < WAIT_LIMIT) begin
      @(negedge clk_wr);
      n++;
      for (int i = 0; i < PHY_CH_N; i++) begin
        found = found | tx_phy[i].mrk;
      end
    end
    if (!found) begin
      err_cnt++;
      $display("Error in %s: no marker on tx_phy after %0d cycles", test_name, n);
    end else begin
      check_count("up_cycles", UP_CYCLES, cyc - c0);
      first_bus = ref_stripe('0, 1'b1, 1'b1);
      for (int i = 0; i < PHY_CH_N; i++) begin
        check_phy($sformatf("first tx_phy[%0d]", i), first_bus[i], tx_phy[i]);
      end
    end
    end_test();

    start_test("striping");
    stb_seen = 0;
    repeat (2 * STROBE_PERIOD) send_word(rand_word(1'b1), 1'b1, 1'b0);
    wait_drain();
    check_count("strobes", 32'd2, stb_seen);
    end_test();

    start_test("loopback");
    for (n = 0; n < 200; n++) begin
      r = lcg_next();
      send_word(rand_word(r[1:0] != 2'd0), 1'b1, 1'b0);
    end
    wait_drain();
    check_count("tx_dbg", n_valid_sent, tx_downstream_debug_status);
    end_test();

    start_test("marker_fault");
    rx_base = rx_upstream_debug_status;
    repeat (4) send_word(rand_word(1'b1), 1'b1, 1'b0);
    repeat (3) send_word(rand_word(1'b1), 1'b1, 1'b1);
    repeat (4) send_word(rand_word(1'b1), 1'b1, 1'b0);
    wait_drain();
    check_count("rx_dbg", rx_base + 32'd3, rx_upstream_debug_status);
    end_test();

    // Word driven with the drop still goes out, later ones do not
    start_test("offline");
    @(posedge clk_wr);
    #2;
    tx_online = 1'b0;
    dstrm     = '0;
    repeat (6) send_word(rand_word(1'b1), 1'b0, 1'b0);
    wait_drain();
    check_count("tx_dbg", n_valid_sent, tx_downstream_debug_status);
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed, chk_cnt,
             err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+tb
src/lpif_link_pkg.sv
src/lpif_auto_sync.sv
src/lpif_user_pack.sv
src/lpif_phy_stripe.sv
src/lpif_link_master_top.sv
tb/tb_lpif_link.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lpif_link
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
